//--- dv/tb_starforce_video.sv
// testbench for the scanline pixel pipeline, random tiles and sprite checked against a pixel model
`default_nettype none

module tb_starforce_video import starforce_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          CLK_PERIOD_NS = 4;
   localparam int          RESET_CYCLES  = 10;
   localparam int          RUN_LINES     = 6;
   localparam int          WATCHDOG_NS   = 2 * RUN_LINES * H_TOTAL * PIX_DIV * CLK_PERIOD_NS;
   localparam logic [15:0] LFSR_SEED     = 16'd15698;

   logic             clk;
   logic             CR;
   logic             tile_send_i;
   logic [15:0]      tile_word_i;
   logic             credit_o;
   logic [7:0]       sprite_x_i;
   logic [7:0]       sprite_pattern_i;
   logic [4:0]       sprite_color_i;
   logic [PAL_W-1:0] pixel_o;
   logic             pixel_valid_o;
   logic             hblank_o;

   logic [15:0] lfsr_state;
   logic [31:0] tile_q [$];
   logic [31:0] cur_tile;
   logic [15:0] attr_word;
   int          credits;
   int          gap;
   int          screen_x;
   int          line_no;
   int          sprite_wins;
   int          prio_covers;
   bit          send_on;
   bit          stop_send;
   bit          want_attr;
   bit          hblank_q;
   bit          run_done;

   starforce_video_top u_starforce_video_top (
      .clk              (clk),
      .CR               (CR),
      .tile_send_i      (tile_send_i),
      .tile_word_i      (tile_word_i),
      .credit_o         (credit_o),
      .sprite_x_i       (sprite_x_i),
      .sprite_pattern_i (sprite_pattern_i),
      .sprite_color_i   (sprite_color_i),
      .pixel_o          (pixel_o),
      .pixel_valid_o    (pixel_valid_o),
      .hblank_o         (hblank_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD_NS / 2) clk = ~clk;
   end

   // ============================================================
   // random source and pixel model
   // ============================================================
   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic string test_name(input int ln);
      if (ln < 2)
         return "tile_pixels";
      else if (ln < 4)
         return "sprite_overlap";
      else
         return "credit_drain";
   endfunction

   task automatic predict_pixel(input logic [31:0] tile, input int col_x,
                                output logic [PAL_W-1:0] index, output logic opaque);
      tile_word_u attr;
      tile_word_u data;
      int         bit_sel;
      int         spr_col;
      logic [1:0] pix;
      attr = tile[31:16];
      data = tile[15:0];
      // leftmost pixel is bit 7 unless flipped
      if (attr.attr.flip)
         bit_sel = col_x % TILE_W;
      else
         bit_sel = TILE_W - 1 - (col_x % TILE_W);
      pix     = {data.data.plane1[bit_sel], data.data.plane0[bit_sel]};
      spr_col = col_x - int'(sprite_x_i);
      opaque  = 1'b0;
      if (spr_col >= 0 && spr_col < TILE_W)
         opaque = sprite_pattern_i[TILE_W - 1 - spr_col];
      if (attr.attr.prio && pix != 2'b00)
         index = {LAYER_TILE, attr.attr.color, pix};
      else if (opaque)
         index = {LAYER_SPRITE, sprite_color_i};
      else if (pix != 2'b00)
         index = {LAYER_TILE, attr.attr.color, pix};
      else
         index = '0;
   endtask

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // new sprite per line once the overlap tests start, sending stops for the drain
   task automatic start_line(input int ln);
      if (ln >= 2)
      begin
         sprite_x_i       = 8'(rand_bits(8));
         sprite_pattern_i = 8'(rand_bits(8));
         sprite_color_i   = 5'(rand_bits(5));
      end
      if (ln == 4)
         stop_send = 1'b1;
   endtask

   // ============================================================
   // per-cycle observation and sending
   // ============================================================
   task automatic observe_outputs();
      logic [PAL_W-1:0] expected;
      logic             opaque;
      string            name;
      name = test_name(line_no);
      if (credit_o)
         credits++;
      assert (credits >= 0 && credits <= TILE_BUF_DEPTH)
      else
         abort_run($sformatf("credit count %0d is outside 0 to %0d", credits, TILE_BUF_DEPTH));
      if (pixel_valid_o)
      begin
         assert (!hblank_o)
         else
            abort_run("pixel_valid_o pulsed while hblank_o was high");
         assert (screen_x < ACTIVE_PIXELS)
         else
            abort_run($sformatf("line %0d carries more than %0d pixels", line_no, ACTIVE_PIXELS));
         // the last line runs on an empty buffer
         if (line_no == RUN_LINES - 1)
         begin
            assert (pixel_o[PAL_W-1 -: 2] != LAYER_TILE)
            else
               abort_run($sformatf({"error: test %s x %0d expected backdrop or sprite layer",
                                    " actual layer %0d"},
                                   name, screen_x, pixel_o[PAL_W-1 -: 2]));
         end
         // tile boundary, empty queue means the buffer underran
         if (screen_x % TILE_W == 0)
         begin
            if (tile_q.size() > 0)
               cur_tile = tile_q.pop_front();
            else
               cur_tile = '0;
         end
         predict_pixel(cur_tile, screen_x, expected, opaque);
         assert (pixel_o == expected)
         else
            abort_run($sformatf("error: test %s line %0d x %0d expected %02h actual %02h",
                                name, line_no, screen_x, expected, pixel_o));
         if (expected[PAL_W-1 -: 2] == LAYER_SPRITE)
            sprite_wins++;
         if (opaque && expected[PAL_W-1 -: 2] == LAYER_TILE)
            prio_covers++;
         screen_x++;
         send_on = 1'b1;
      end
      if (hblank_o && !hblank_q)
      begin
         assert (screen_x == ACTIVE_PIXELS)
         else
            abort_run($sformatf("error: test %s line %0d expected %0d pixels actual %0d",
                                name, line_no, ACTIVE_PIXELS, screen_x));
         screen_x = 0;
         line_no++;
         if (line_no == RUN_LINES)
         begin
            assert (credits == TILE_BUF_DEPTH)
            else
               abort_run($sformatf("error: test credit_drain expected %0d credits actual %0d",
                                   TILE_BUF_DEPTH, credits));
            run_done = 1'b1;
         end
         else
            start_line(line_no);
      end
      hblank_q = hblank_o;
   endtask

   // attribute word then data word, one credit each
   task automatic send_words();
      logic [15:0] data_word;
      tile_send_i = 1'b0;
      if (!send_on || (stop_send && want_attr))
         return;
      if (gap > 0)
      begin
         gap--;
         return;
      end
      if (credits == 0)
         return;
      if (want_attr)
      begin
         attr_word   = 16'(rand_bits(16));
         tile_word_i = attr_word;
      end
      else
      begin
         data_word   = 16'(rand_bits(16));
         tile_word_i = data_word;
         tile_q.push_back({attr_word, data_word});
      end
      tile_send_i = 1'b1;
      credits--;
      want_attr = !want_attr;
      gap = int'(rand_bits(2));
   endtask

   // ============================================================
   // main sequence
   // ============================================================
   initial
   begin
      CR               = 1'b1;
      tile_send_i      = 1'b0;
      tile_word_i      = '0;
      sprite_x_i       = 8'd255;
      sprite_pattern_i = 8'd0;
      lfsr_state       = LFSR_SEED;
      sprite_color_i   = 5'(rand_bits(5));
      cur_tile         = '0;
      attr_word        = '0;
      credits          = TILE_BUF_DEPTH;
      gap              = 0;
      screen_x         = 0;
      line_no          = 0;
      sprite_wins      = 0;
      prio_covers      = 0;
      send_on          = 1'b0;
      stop_send        = 1'b0;
      want_attr        = 1'b1;
      hblank_q         = 1'b1;
      run_done         = 1'b0;
      @(negedge clk);
      CR = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      CR = 1'b1;
      @(negedge clk);
      assert (credit_o == 1'b0)
      else
         abort_run($sformatf("error: test reset expected credit_o 0 actual %0d", credit_o));
      assert (pixel_valid_o == 1'b0)
      else
         abort_run($sformatf("error: test reset expected pixel_valid_o 0 actual %0d",
                             pixel_valid_o));
      assert (hblank_o == 1'b1)
      else
         abort_run($sformatf("error: test reset expected hblank_o 1 actual %0d", hblank_o));
      while (!run_done)
      begin
         @(negedge clk);
         observe_outputs();
         send_words();
      end
      $display("sprite pixels %0d, priority tiles over sprite %0d", sprite_wins, prio_covers);
      assert (sprite_wins > 0)
      else
         abort_run("no sprite pixel won over the tiles during the run");
      assert (prio_covers > 0)
      else
         abort_run("no priority tile covered an opaque sprite pixel during the run");
      $display("Test passed");
      $finish;
   end

   // watchdog, twice the time of the whole run
   initial
   begin
      #(WATCHDOG_NS);
      abort_run($sformatf("timeout: run did not finish within %0d ns", WATCHDOG_NS));
   end

endmodule

`default_nettype wire

//--- src/layer_priority.sv
// ls148-style layer select between tile, sprite and backdrop, registers the palette index
`default_nettype none

module layer_priority import starforce_pkg::*;
(
   input  wire                clk,
   input  wire                CR,
   input  wire                pix_strobe_i,
   input  wire  [1:0]         tile_pix_i,
   input  wire  [2:0]         tile_color_i,
   input  wire                tile_prio_i,
   input  wire                sprite_opaque_i,
   input  wire  [4:0]         sprite_color_i,
   output logic [PAL_W-1:0]   pixel_o,
   output logic               pixel_valid_o
);

   logic             tile_nz;
   logic [2:0]       req;
   logic [1:0]       win;
   logic [PAL_W-1:0] index;

   // pixel value 0 is transparent
   assign tile_nz = |tile_pix_i;

   // request lines, highest priority first
   assign req = {tile_prio_i & tile_nz, sprite_opaque_i, tile_nz};

   always_comb
   begin
      casez (req)
         3'b1??:  win = LAYER_TILE;
         3'b01?:  win = LAYER_SPRITE;
         3'b001:  win = LAYER_TILE;
         default: win = LAYER_BACKDROP;
      endcase
      case (win)
         LAYER_TILE:   index = {LAYER_TILE, tile_color_i, tile_pix_i};
         LAYER_SPRITE: index = {LAYER_SPRITE, sprite_color_i};
         default:      index = {LAYER_BACKDROP, {(PAL_W - 2){1'b0}}};
      endcase
   end

   // ============================================================
   // output register
   // ============================================================
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         pixel_o       <= '0;
         pixel_valid_o <= 1'b0;
      end
      else
      begin
         pixel_valid_o <= pix_strobe_i;
         if (pix_strobe_i)
            pixel_o <= index;
      end
   end

endmodule

`default_nettype wire

//--- src/pixel_timing.sv
// pixel clock enable and horizontal beam counter with blanking, the timebase of the pipeline
`default_nettype none

module pixel_timing import starforce_pkg::*;
(
   input  wire                clk,
   input  wire                CR,
   output logic               pix_cen_o,
   output logic [HPOS_W-1:0]  hpos_o,
   output logic               hblank_o
);

   logic [1:0]        div_cnt;
   logic              div_msb_q;
   logic [HPOS_W-1:0] hpos_next;
   logic              next_active;

   // divider, enable taken from the rising edge of its msb
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         div_cnt   <= 2'd2;
         div_msb_q <= 1'b0;
         pix_cen_o <= 1'b0;
      end
      else
      begin
         if (div_cnt == 2'(PIX_DIV - 1))
            div_cnt <= 2'd0;
         else
            div_cnt <= div_cnt + 2'd1;
         div_msb_q <= div_cnt[1];
         pix_cen_o <= div_cnt[1] & ~div_msb_q;
      end
   end

   always_comb
   begin
      if (hpos_o == HPOS_W'(H_TOTAL - 1))
         hpos_next = '0;
      else
         hpos_next = hpos_o + 1'b1;
      next_active = (hpos_next >= HPOS_W'(ACTIVE_START)) &&
                    (hpos_next < HPOS_W'(ACTIVE_START + ACTIVE_PIXELS));
   end

   // beam steps two cycles after the enable, once that pixel has left the pipeline
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         hpos_o   <= '0;
         hblank_o <= 1'b1;
      end
      else if (div_cnt == 2'd1)
      begin
         hpos_o   <= hpos_next;
         hblank_o <= ~next_active;
      end
   end

endmodule

`default_nettype wire

//--- src/plane_shifter.sv
// ls194 pair of bitplane shifters with attribute latch, serializes one tile per 8 pixels
`default_nettype none

module plane_shifter import starforce_pkg::*;
(
   input  wire                clk,
   input  wire                CR,
   input  wire                pix_cen_i,
   input  wire  [HPOS_W-1:0]  hpos_i,
   input  wire                hblank_i,
   input  wire                tile_ready_i,
   input  wire  tile_word_u   head_word_i,
   input  wire  tile_word_u   next_word_i,
   output logic               tile_pop_o,
   output logic [1:0]         tile_pix_o,
   output logic [2:0]         tile_color_o,
   output logic               tile_prio_o,
   output logic               pix_strobe_o
);

   logic [7:0] plane0_q;
   logic [7:0] plane1_q;
   logic [7:0] load0;
   logic [7:0] load1;
   logic       flip_q;
   logic       active_cen;
   logic       tile_start;
   logic [1:0] mode;
   tile_word_u load_attr;

   assign active_cen = pix_cen_i & ~hblank_i;
   assign tile_start = active_cen && (hpos_i[$clog2(TILE_W)-1:0] == '0);
   assign tile_pop_o = tile_start & tile_ready_i;

   always_comb
   begin
      // underrun gives an all-transparent tile
      if (tile_pop_o)
      begin
         load_attr = head_word_i;
         load0     = next_word_i.data.plane0;
         load1     = next_word_i.data.plane1;
      end
      else
      begin
         load_attr = '0;
         load0     = '0;
         load1     = '0;
      end
      // S lines as on the ls194
      if (tile_start)
         mode = 2'b11;
      else if (active_cen)
         mode = flip_q ? 2'b10 : 2'b01;
      else
         mode = 2'b00;
   end

   // ============================================================
   // shift registers
   // ============================================================
   always_ff @(posedge clk)
   begin
      case (mode)
         2'b11:
         begin
            plane0_q <= load0;
            plane1_q <= load1;
         end
         2'b01:
         begin
            plane0_q <= {plane0_q[6:0], 1'b0};
            plane1_q <= {plane1_q[6:0], 1'b0};
         end
         2'b10:
         begin
            plane0_q <= {1'b0, plane0_q[7:1]};
            plane1_q <= {1'b0, plane1_q[7:1]};
         end
         default:
         begin
            plane0_q <= plane0_q;
            plane1_q <= plane1_q;
         end
      endcase
   end

   // attribute latch and pixel marker
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         flip_q       <= 1'b0;
         tile_color_o <= '0;
         tile_prio_o  <= 1'b0;
         pix_strobe_o <= 1'b0;
      end
      else
      begin
         pix_strobe_o <= active_cen;
         if (tile_start)
         begin
            flip_q       <= load_attr.attr.flip;
            tile_color_o <= load_attr.attr.color;
            tile_prio_o  <= load_attr.attr.prio;
         end
      end
   end

   // flipped tiles read out from the lsb end
   assign tile_pix_o = flip_q ? {plane1_q[0], plane0_q[0]} : {plane1_q[7], plane0_q[7]};

endmodule

`default_nettype wire

//--- src/sprite_hit.sv
// sprite column finder, ls283 subtract and ls85 range test, gives the sprite pixel per beam position
`default_nettype none

module sprite_hit import starforce_pkg::*;
(
   input  wire                clk,
   input  wire                CR,
   input  wire                pix_cen_i,
   input  wire  [HPOS_W-1:0]  hpos_i,
   input  wire  [7:0]         sprite_x_i,
   input  wire  [7:0]         sprite_pattern_i,
   output logic               sprite_opaque_o
);

   logic [HPOS_W-1:0] sub_val;
   logic [HPOS_W-1:0] col;
   logic              no_borrow;
   logic              in_tile;
   logic              pat_bit;

   // left edge of the sprite in beam coordinates
   assign sub_val = HPOS_W'(ACTIVE_START) + HPOS_W'(sprite_x_i);

   // adder chain, a - b as a + ~b + 1
   // carry out set means the beam is at or right of the sprite
   assign {no_borrow, col} = {1'b0, hpos_i} + {1'b0, ~sub_val} + 1'b1;

   // magnitude test against the sprite width
   assign in_tile = no_borrow && (col < HPOS_W'(TILE_W));

   // bit 7 is the leftmost column
   assign pat_bit = sprite_pattern_i[3'd7 - col[$clog2(TILE_W)-1:0]];

   // sampled on the enable, lines up with the shifter output
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         sprite_opaque_o <= 1'b0;
      else if (pix_cen_i)
         sprite_opaque_o <= in_tile & pat_bit;
   end

endmodule

`default_nettype wire

//--- src/starforce_pkg.sv
// shared sizes, layer codes and tile word type, imported by every module of the pixel pipeline
`default_nettype none

package starforce_pkg;

   // ============================================================
   // beam timing
   // ============================================================
   localparam int PIX_DIV       = 4;
   localparam int H_TOTAL       = 320;
   localparam int ACTIVE_START  = 16;
   localparam int ACTIVE_PIXELS = 256;
   localparam int HPOS_W        = 9;

   // ============================================================
   // tiles and palette
   // ============================================================
   localparam int TILE_W         = 8;
   localparam int TILE_BUF_DEPTH = 4;
   localparam int PAL_W          = 7;

   // layer code sits in the top two bits of the palette index
   localparam logic [1:0] LAYER_BACKDROP = 2'd0;
   localparam logic [1:0] LAYER_TILE     = 2'd1;
   localparam logic [1:0] LAYER_SPRITE   = 2'd2;

   // one host word, read either as attributes or as two bitplanes
   typedef union packed {
      struct packed {
         logic [10:0] reserved;
         logic        prio;
         logic        flip;
         logic [2:0]  color;
      } attr;
      struct packed {
         logic [7:0] plane1;
         logic [7:0] plane0;
      } data;
   } tile_word_u;

endpackage

`default_nettype wire

//--- src/starforce_video_top.sv
// top of the tile and sprite scanline pipeline, connects timing, buffer, shifter, sprite and mixer
`default_nettype none

module starforce_video_top import starforce_pkg::*;
(
   input  wire                clk,
   input  wire                CR,
   input  wire                tile_send_i,
   input  wire  [15:0]        tile_word_i,
   output logic               credit_o,
   input  wire  [7:0]         sprite_x_i,
   input  wire  [7:0]         sprite_pattern_i,
   input  wire  [4:0]         sprite_color_i,
   output logic [PAL_W-1:0]   pixel_o,
   output logic               pixel_valid_o,
   output logic               hblank_o
);

   logic              pix_cen;
   logic [HPOS_W-1:0] hpos;
   tile_word_u        head_word;
   tile_word_u        next_word;
   logic              tile_ready;
   logic              tile_pop;
   logic [1:0]        tile_pix;
   logic [2:0]        tile_color;
   logic              tile_prio;
   logic              pix_strobe;
   logic              sprite_opaque;

   pixel_timing u_pixel_timing (
      .clk       (clk),
      .CR        (CR),
      .pix_cen_o (pix_cen),
      .hpos_o    (hpos),
      .hblank_o  (hblank_o)
   );

   tile_word_buffer u_tile_word_buffer (
      .clk          (clk),
      .CR           (CR),
      .tile_send_i  (tile_send_i),
      .tile_word_i  (tile_word_i),
      .tile_pop_i   (tile_pop),
      .head_word_o  (head_word),
      .next_word_o  (next_word),
      .tile_ready_o (tile_ready),
      .credit_o     (credit_o)
   );

   plane_shifter u_plane_shifter (
      .clk          (clk),
      .CR           (CR),
      .pix_cen_i    (pix_cen),
      .hpos_i       (hpos),
      .hblank_i     (hblank_o),
      .tile_ready_i (tile_ready),
      .head_word_i  (head_word),
      .next_word_i  (next_word),
      .tile_pop_o   (tile_pop),
      .tile_pix_o   (tile_pix),
      .tile_color_o (tile_color),
      .tile_prio_o  (tile_prio),
      .pix_strobe_o (pix_strobe)
   );

   sprite_hit u_sprite_hit (
      .clk              (clk),
      .CR               (CR),
      .pix_cen_i        (pix_cen),
      .hpos_i           (hpos),
      .sprite_x_i       (sprite_x_i),
      .sprite_pattern_i (sprite_pattern_i),
      .sprite_opaque_o  (sprite_opaque)
   );

   layer_priority u_layer_priority (
      .clk             (clk),
      .CR              (CR),
      .pix_strobe_i    (pix_strobe),
      .tile_pix_i      (tile_pix),
      .tile_color_i    (tile_color),
      .tile_prio_i     (tile_prio),
      .sprite_opaque_i (sprite_opaque),
      .sprite_color_i  (sprite_color_i),
      .pixel_o         (pixel_o),
      .pixel_valid_o   (pixel_valid_o)
   );

endmodule

`default_nettype wire

//--- src/tile_word_buffer.sv
// four-word buffer between the host tile stream and the shifter, paid back in credits
`default_nettype none

module tile_word_buffer import starforce_pkg::*;
(
   input  wire               clk,
   input  wire               CR,
   input  wire               tile_send_i,
   input  wire        [15:0] tile_word_i,
   input  wire               tile_pop_i,
   output tile_word_u        head_word_o,
   output tile_word_u        next_word_o,
   output logic              tile_ready_o,
   output logic              credit_o
);

   tile_word_u                        mem [TILE_BUF_DEPTH];
   logic [$clog2(TILE_BUF_DEPTH)-1:0] wr_ptr;
   logic [$clog2(TILE_BUF_DEPTH)-1:0] rd_ptr;
   logic [$clog2(TILE_BUF_DEPTH)-1:0] rd_ptr_pair;
   logic [$clog2(TILE_BUF_DEPTH):0]   fill;
   logic [$clog2(TILE_BUF_DEPTH):0]   fill_next;
   logic [2:0]                        pend;
   logic [2:0]                        pend_sum;

   // storage, sender never overruns thanks to credits
   always_ff @(posedge clk)
   begin
      if (tile_send_i)
         mem[wr_ptr] <= tile_word_u'(tile_word_i);
   end

   assign rd_ptr_pair  = rd_ptr + 1'b1;
   assign head_word_o  = mem[rd_ptr];
   assign next_word_o  = mem[rd_ptr_pair];
   assign tile_ready_o = (fill >= 2);

   always_comb
   begin
      fill_next = fill;
      if (tile_send_i)
         fill_next = fill_next + 1'b1;
      if (tile_pop_i)
         fill_next = fill_next - 2'd2;
      // each pop frees an attribute slot and a data slot
      pend_sum = pend;
      if (tile_pop_i)
         pend_sum = pend_sum + 3'd2;
   end

   // ============================================================
   // pointers, fill level, credit return
   // ============================================================
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         fill     <= '0;
         pend     <= '0;
         credit_o <= 1'b0;
      end
      else
      begin
         if (tile_send_i)
            wr_ptr <= wr_ptr + 1'b1;
         if (tile_pop_i)
            rd_ptr <= rd_ptr + 2'd2;
         fill <= fill_next;
         // one credit pulse per freed slot
         credit_o <= (pend_sum != '0);
         if (pend_sum != '0)
            pend <= pend_sum - 3'd1;
         else
            pend <= '0;
      end
   end

endmodule

`default_nettype wire

//--- vlog.f
src/starforce_pkg.sv
src/pixel_timing.sv
src/tile_word_buffer.sv
src/plane_shifter.sv
src/sprite_hit.sv
src/layer_priority.sv
src/starforce_video_top.sv
dv/tb_starforce_video.sv
